// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uart_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
rtl/uart_bus_pkg.sv
rtl/uart_line_pkg.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verification/uart_tb.sv

// File: rtl/uart_bus_pkg.sv
// UART bus side definitions

package uart_bus_pkg;

    // register offsets, matched against addr[3:0]
    localparam logic [3:0] UART_CR = 4'h0;     // control and status
    localparam logic [3:0] UART_TX = 4'h1;     // transmit byte
    localparam logic [3:0] UART_RX = 4'h2;     // last received byte
    localparam logic [3:0] UART_DR = 4'h3;     // baud divider

    // one bus write as seen by the register block.
    // only the low address nibble is decoded,
    // so the upper address bits never reach this struct
    typedef struct packed {
        logic [3:0]     addr;       // register offset
        logic           we;         // write strobe
        logic [31:0]    wd;         // write data
    } bus_wr_t;

endpackage : uart_bus_pkg

// File: rtl/uart_line_pkg.sv
// UART line side types and frame constants

package uart_line_pkg;

    localparam int DATA_BITS  = 8;      // payload bits per frame
    localparam int FRAME_BITS = 10;     // start + data + stop

    // CR layout, tx_req in bit 0
    typedef struct packed {
        logic [3:0]     reserved;   // read back as written
        logic           rx_en;      // receiver enable
        logic           tx_en;      // transmitter enable
        logic           rx_valid;   // set by hw on a received byte
        logic           tx_req;     // cleared by hw at end of frame
    } uart_ctrl_t;

    // bus loads the byte, logic works on fields
    typedef union packed {
        logic [7:0]     raw;
        uart_ctrl_t     fields;
    } ctrl_word_u;

    // command to the transmitter
    typedef struct packed {
        logic                   en;
        logic                   req;
        logic [DATA_BITS-1:0]   data;
        logic [15:0]            comp;   // clocks per bit
    } tx_cmd_t;

    typedef struct packed {
        logic           en;
        logic [15:0]    comp;
    } rx_cfg_t;

    // valid is a single cycle pulse
    typedef struct packed {
        logic                   valid;
        logic [DATA_BITS-1:0]   data;
    } rx_result_t;

endpackage : uart_line_pkg

// File: rtl/uart_regs.sv
// UART register block and read mux

`timescale 1ns/100ps

module uart_regs
(
    input   logic                           clk,        // system clock
    input   logic                           rst_n,      // async reset, active low
    input   uart_bus_pkg::bus_wr_t          bus,        // address, strobe, write data
    output  logic   [31:0]                  rd,         // read data
    output  uart_line_pkg::tx_cmd_t         tx_cmd,     // to transmitter
    input   logic                           done,       // frame sent
    output  uart_line_pkg::rx_cfg_t         rx_cfg,     // to receiver
    input   uart_line_pkg::rx_result_t      rx_res      // from receiver
);

    uart_line_pkg::ctrl_word_u  cr;
    logic   [7:0]               tx_data;
    logic   [7:0]               rx_data;
    logic   [15:0]              comp;       // baud divider

    logic                       cr_we;
    logic                       tx_we;
    logic                       dr_we;

    // per register write strobes, RX is read only
    assign cr_we = bus.we && (bus.addr == uart_bus_pkg::UART_CR);
    assign tx_we = bus.we && (bus.addr == uart_bus_pkg::UART_TX);
    assign dr_we = bus.we && (bus.addr == uart_bus_pkg::UART_DR);

    // control word, bus write beats hw updates
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cr.raw <= '0;
        end
        else if (cr_we)
        begin
            cr.raw <= bus.wd[7:0];
        end
        else
        begin
            if (done)
                cr.fields.tx_req <= 1'b0;       // frame is out
            if (rx_res.valid)
                cr.fields.rx_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tx_data <= '0;
            comp    <= '0;
        end
        else
        begin
            if (tx_we)
                tx_data <= bus.wd[7:0];
            if (dr_we)
                comp <= bus.wd[15:0];
        end
    end

    // newest byte always wins
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rx_data <= '0;
        else if (rx_res.valid)
            rx_data <= rx_res.data;
    end

    assign tx_cmd = '{
        en   : cr.fields.tx_en,
        req  : cr.fields.tx_req,
        data : tx_data,
        comp : comp
    };

    assign rx_cfg = '{en : cr.fields.rx_en, comp : comp};

    always_comb
    begin
        rd = '0;
        case (bus.addr)
            uart_bus_pkg::UART_CR : rd = {24'h0, cr.fields};
            uart_bus_pkg::UART_TX : rd = {24'h0, tx_data};
            uart_bus_pkg::UART_RX : rd = {24'h0, rx_data};
            uart_bus_pkg::UART_DR : rd = {16'h0, comp};
            default               : rd = '0;
        endcase
    end

endmodule : uart_regs

// File: rtl/uart_rx.sv
// UART receiver, 8N1

`timescale 1ns/100ps

module uart_rx
(
    input   logic                           clk,        // system clock
    input   logic                           rst_n,      // async reset, active low
    input   uart_line_pkg::rx_cfg_t         cfg,        // enable and divider
    output  uart_line_pkg::rx_result_t      rx_res,     // byte and valid pulse
    input   logic                           uart_rx     // serial line
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t                                      state;
    logic   [2:0]                                   rx_sync;    // two sync flops + history
    logic   [15:0]                                  baud_cnt;
    logic   [$clog2(uart_line_pkg::DATA_BITS)-1:0]  bit_idx;
    logic   [uart_line_pkg::DATA_BITS-1:0]          data_sr;
    logic                                           valid_q;
    logic                                           line;
    logic                                           fall;
    logic                                           half_end;
    logic                                           bit_end;

    assign line     = rx_sync[1];
    assign fall     = rx_sync[2] && !rx_sync[1];
    assign half_end = (baud_cnt >= {1'b0, cfg.comp[15:1]} - 16'd1);
    assign bit_end  = (baud_cnt >= cfg.comp - 16'd1);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rx_sync <= '1;
        else
            rx_sync <= {rx_sync[1:0], uart_rx};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            case (state)
                RX_IDLE :
                    if (cfg.en && fall && (cfg.comp != '0))
                    begin
                        state    <= RX_START;
                        baud_cnt <= '0;
                    end
                RX_START :                          // middle of start bit
                    if (half_end)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= line ? RX_IDLE : RX_DATA;   // glitch, back off
                    end
                    else
                        baud_cnt <= baud_cnt + 16'd1;
                RX_DATA :
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        if (int'(bit_idx) == uart_line_pkg::DATA_BITS - 1)
                            state <= RX_STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        baud_cnt <= baud_cnt + 16'd1;
                RX_STOP :
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        valid_q  <= line;           // bad stop bit drops the byte
                        state    <= RX_IDLE;
                    end
                    else
                        baud_cnt <= baud_cnt + 16'd1;
                default :
                    state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, shifts in from the top
    always_ff @(posedge clk)
    begin
        if ((state == RX_DATA) && bit_end)
            data_sr <= {line, data_sr[uart_line_pkg::DATA_BITS-1:1]};
    end

    assign rx_res = '{valid : valid_q, data : data_sr};

endmodule : uart_rx

// File: rtl/uart_top.sv
// UART peripheral top level

`timescale 1ns/100ps

module uart_top
(
    // clock and reset
    input   logic           clk,        // system clock
    input   logic           rst_n,      // async reset, active low
    // bus side
    input   logic   [31:0]  addr,       // address
    input   logic           we,         // write enable
    input   logic   [31:0]  wd,         // write data
    output  logic   [31:0]  rd,         // read data
    // serial side
    output  logic           uart_tx,    // tx line
    input   logic           uart_rx     // rx line
);

    uart_bus_pkg::bus_wr_t          bus;
    uart_line_pkg::tx_cmd_t         tx_cmd;
    uart_line_pkg::rx_cfg_t         rx_cfg;
    uart_line_pkg::rx_result_t      rx_res;
    logic                           done;

    // only the low nibble selects a register
    assign bus = '{addr : addr[3:0], we : we, wd : wd};

    uart_regs uart_regs_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .bus        ( bus       ),
        .rd         ( rd        ),
        .tx_cmd     ( tx_cmd    ),
        .done       ( done      ),
        .rx_cfg     ( rx_cfg    ),
        .rx_res     ( rx_res    )
    );

    uart_tx uart_tx_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .cmd        ( tx_cmd    ),
        .done       ( done      ),
        .uart_tx    ( uart_tx   )
    );

    uart_rx uart_rx_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .cfg        ( rx_cfg    ),
        .rx_res     ( rx_res    ),
        .uart_rx    ( uart_rx   )
    );

endmodule : uart_top

// File: rtl/uart_tx.sv
// UART transmitter, 8N1

`timescale 1ns/100ps

module uart_tx
(
    input   logic                       clk,        // system clock
    input   logic                       rst_n,      // async reset, active low
    input   uart_line_pkg::tx_cmd_t     cmd,        // enable, request, byte, divider
    output  logic                       done,       // last cycle of stop bit
    output  logic                       uart_tx     // serial line
);

    logic                                           busy;       // shifting a frame
    logic   [15:0]                                  baud_cnt;
    logic   [$clog2(uart_line_pkg::FRAME_BITS)-1:0] bit_idx;    // frame position
    logic   [uart_line_pkg::FRAME_BITS-1:0]         frame_sr;   // stop, data, start
    logic                                           start;
    logic                                           bit_end;

    // a zero divider keeps the transmitter idle
    assign start   = !busy && cmd.en && cmd.req && (cmd.comp != '0);
    assign bit_end = (baud_cnt >= cmd.comp - 16'd1);
    assign done    = busy && bit_end && (int'(bit_idx) == uart_line_pkg::FRAME_BITS - 1);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            frame_sr <= '1;             // line idles high
        end
        else if (start)
        begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            frame_sr <= {1'b1, cmd.data, 1'b0};
        end
        else if (busy)
        begin
            if (bit_end)
            begin
                baud_cnt <= '0;
                // ones shift in, so the line is high once the frame ends
                frame_sr <= {1'b1, frame_sr[uart_line_pkg::FRAME_BITS-1:1]};
                if (done)
                    busy <= 1'b0;
                else
                    bit_idx <= bit_idx + 1'b1;
            end
            else
            begin
                baud_cnt <= baud_cnt + 16'd1;
            end
        end
    end

    assign uart_tx = frame_sr[0];       // straight from a flop

endmodule : uart_tx

// File: verification/uart_tb.sv
// UART peripheral testbench

`timescale 1ns/100ps

module uart_tb;

    localparam int CLK_NS      = 40;
    localparam int DR_TEST     = 8;
    localparam int TX_FRAMES   = 4;
    localparam int RX_FRAMES   = 3;
    localparam int FRAME_SLOTS = TX_FRAMES + RX_FRAMES + 2;    // plus both disabled tests
    localparam int WATCHDOG_NS = FRAME_SLOTS * 10 * DR_TEST * CLK_NS * 2 + 200 * CLK_NS;

    logic           clk;
    logic           rst_n;
    logic   [31:0]  addr;
    logic           we;
    logic   [31:0]  wd;
    logic   [31:0]  rd;
    logic           tx_line;
    logic           rx_line;
    logic           loop_en;        // external loopback tx to rx

    int             errors;
    int             checks;
    int             frames_seen;
    integer         seed;
    logic   [7:0]   exp_q[$];       // bytes expected on the tx line
    logic   [7:0]   mon_byte;

    assign rx_line = loop_en ? tx_line : 1'b1;      // idle high when open

    uart_top dut
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .addr       ( addr      ),
        .we         ( we        ),
        .wd         ( wd        ),
        .rd         ( rd        ),
        .uart_tx    ( tx_line   ),
        .uart_rx    ( rx_line   )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // expected line level at frame position 0..9
    function automatic logic frame_bit(input logic [7:0] data, input int index);
        if (index == 0)
            return 1'b0;                // start bit
        else if (index <= 8)
            return data[index - 1];     // lsb first
        else
            return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        assert (act_val === exp_val)
        else
        begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic bus_write(input logic [3:0] offset, input logic [31:0] data);
        @(posedge clk);
        addr <= {28'h0, offset};
        we   <= 1'b1;
        wd   <= data;
        @(posedge clk);
        we   <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] offset, output logic [31:0] data);
        @(posedge clk);
        addr <= {28'h0, offset};
        we   <= 1'b0;
        @(negedge clk);                 // rd settled
        data = rd;
    endtask

    // polls CR until a bit reaches a level, counting clock edges
    task automatic wait_cr_bit(input int pos, input logic level, input int limit,
                               output int cycles);
        cycles = 0;
        while (cycles <= limit)
        begin
            @(posedge clk);
            addr <= {28'h0, uart_bus_pkg::UART_CR};
            cycles++;
            @(negedge clk);
            if (rd[pos] === level)
                return;
        end
        errors++;
        $display("CR bit %0d never reached %0b within %0d cycles", pos, level, limit);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic [7:0] cr_val,
                             output int cycles);
        bus_write(uart_bus_pkg::UART_TX, {24'h0, data});
        exp_q.push_back(data);
        bus_write(uart_bus_pkg::UART_CR, {24'h0, cr_val});
        wait_cr_bit(0, 1'b0, 20 * DR_TEST, cycles);
    endtask

    // line monitor, samples near each bit centre
    initial
    begin
        forever
        begin
            @(negedge tx_line);
            if (rst_n === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("unexpected start bit on the tx line at %0t", $time);
                end
                else
                begin
                    mon_byte = exp_q.pop_front();
                    repeat (DR_TEST / 2) @(negedge clk);
                    for (int i = 0; i < 10; i++)
                    begin
                        if (i > 0)
                            repeat (DR_TEST) @(negedge clk);
                        check_value($sformatf("tx frame bit %0d", i),
                                    {31'h0, frame_bit(mon_byte, i)}, {31'h0, tx_line});
                    end
                    frames_seen++;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        logic   [31:0]  rnd;
        logic   [31:0]  val;
        logic   [31:0]  rx_before;
        logic   [7:0]   data;
        int             cycles;

        errors      = 0;
        checks      = 0;
        frames_seen = 0;
        seed        = 32'hc2e4_3edc;
        rst_n       = 1'b0;
        addr        = '0;
        we          = 1'b0;
        wd          = '0;
        loop_en     = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // reset state
        bus_read(uart_bus_pkg::UART_CR, val);
        check_value("reset CR", 32'h0, val);
        bus_read(uart_bus_pkg::UART_TX, val);
        check_value("reset TX", 32'h0, val);
        bus_read(uart_bus_pkg::UART_RX, val);
        check_value("reset RX", 32'h0, val);
        bus_read(uart_bus_pkg::UART_DR, val);
        check_value("reset DR", 32'h0, val);
        check_value("reset tx line", 32'h1, {31'h0, tx_line});

        // register readback, widths masked
        rnd = $random(seed);
        bus_write(uart_bus_pkg::UART_TX, rnd);
        bus_read(uart_bus_pkg::UART_TX, val);
        check_value("TX readback", {24'h0, rnd[7:0]}, val);
        rnd = $random(seed);
        bus_write(uart_bus_pkg::UART_DR, rnd);
        bus_read(uart_bus_pkg::UART_DR, val);
        check_value("DR readback", {16'h0, rnd[15:0]}, val);
        rnd = $random(seed);
        bus_write(uart_bus_pkg::UART_RX, rnd);
        bus_read(uart_bus_pkg::UART_RX, val);
        check_value("RX write ignored", 32'h0, val);
        bus_write(uart_bus_pkg::UART_DR, DR_TEST);

        // transmit random bytes, tx_en and tx_req
        for (int n = 0; n < TX_FRAMES; n++)
        begin
            rnd  = $random(seed);
            data = rnd[7:0];
            send_byte(data, 8'h05, cycles);
            check_value("tx done latency", 1 + 10 * DR_TEST, cycles);
        end
        check_value("tx frames seen", TX_FRAMES, frames_seen);

        // request with tx_en clear, line must stay idle
        bus_write(uart_bus_pkg::UART_CR, 32'h01);
        repeat (10 * DR_TEST)
        begin
            @(negedge clk);
            check_value("tx disabled line", 32'h1, {31'h0, tx_line});
        end
        bus_read(uart_bus_pkg::UART_CR, val);
        check_value("tx disabled req held", 32'h01, val);
        bus_write(uart_bus_pkg::UART_CR, 32'h00);

        // loopback receive
        @(posedge clk);
        loop_en <= 1'b1;
        for (int n = 0; n < RX_FRAMES; n++)
        begin
            rnd  = $random(seed);
            data = rnd[7:0];
            send_byte(data, 8'h0d, cycles);
            wait_cr_bit(1, 1'b1, 4 * DR_TEST, cycles);
            bus_read(uart_bus_pkg::UART_RX, val);
            check_value("rx byte", {24'h0, data}, val);
            bus_read(uart_bus_pkg::UART_CR, val);
            check_value("rx CR after frame", 32'h0e, val);
            bus_write(uart_bus_pkg::UART_CR, 32'h0c);   // clear rx_valid
            bus_read(uart_bus_pkg::UART_CR, val);
            check_value("rx_valid cleared", 32'h0c, val);
        end

        // rx_en clear, looped frame ignored
        bus_read(uart_bus_pkg::UART_RX, rx_before);
        rnd  = $random(seed);
        data = rnd[7:0];
        send_byte(data, 8'h05, cycles);
        repeat (2 * DR_TEST) @(posedge clk);            // past the stop bit centre
        bus_read(uart_bus_pkg::UART_CR, val);
        check_value("rx disabled CR", 32'h04, val);
        bus_read(uart_bus_pkg::UART_RX, val);
        check_value("rx disabled RX", rx_before, val);
        check_value("all frames seen", TX_FRAMES + RX_FRAMES + 1, frames_seen);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule : uart_tb
